// ==== compile.f ====
source/Rv32Pkg.sv
source/InstDecoder.sv
source/Controller.sv
source/RegisterFile.sv
source/BranchUnit.sv
source/StageID.sv
source/DecodeTop.sv
tb/DecodeTop_props.sv
tb/DecodeTop_tb.sv

// ==== source/BranchUnit.sv ====
`timescale 1ns/100ps

module BranchUnit (
    input  Rv32Pkg::Pc_t    i_Pc,
    input  Rv32Pkg::Word_t  i_Imm,
    input  Rv32Pkg::Word_t  i_DataA,           // rs1
    input  Rv32Pkg::Word_t  i_DataB,           // rs2
    input  logic            i_Unsigned,        // BLTU and BGEU
    input  Rv32Pkg::PcSel_t i_PcNextSel,
    output logic            o_IsEq,
    output logic            o_IsLt,
    output Rv32Pkg::Pc_t    o_PcNext
);
    import Rv32Pkg::*;

    Pc_t pcPlus4;
    Pc_t pcRel;
    Word_t regSum;                              // rs1 + imm before masking

    // ----------------------------------------
    // Compare, independent of the PC select
    // ----------------------------------------

    assign o_IsEq = (i_DataA == i_DataB);
    assign o_IsLt = i_Unsigned ? (i_DataA < i_DataB)
                               : ($signed(i_DataA) < $signed(i_DataB));

    // ----------------------------------------
    // Target addresses
    // ----------------------------------------

    assign pcPlus4 = i_Pc + Pc_t'(4);
    assign pcRel   = i_Pc + Pc_t'(i_Imm);
    assign regSum  = i_DataA + i_Imm;

    always_comb begin
        case (i_PcNextSel)
            PC_REL:  o_PcNext = pcRel;
            PC_REG:  o_PcNext = {regSum[PC_WIDTH-1:1], 1'b0};  // JALR clears bit 0
            default: o_PcNext = pcPlus4;
        endcase
    end

endmodule

// ==== source/Controller.sv ====
`timescale 1ns/100ps

module Controller (
    input  Rv32Pkg::Opcode_t    i_Op,
    input  logic [2:0]          i_Funct3,
    input  logic                i_Funct7b5,
    input  logic                i_IsEq,         // rs1 == rs2
    input  logic                i_IsLt,         // rs1 < rs2
    output Rv32Pkg::AluOp       o_AluControl,
    output logic                o_RegWrEnable,
    output logic                o_MemWrEnable,
    output Rv32Pkg::WrDataSel_t o_RegWrDataSel,
    output logic                o_OperandASel,  // 1 selects PC
    output logic                o_OperandBSel,  // 1 selects immediate
    output logic                o_CmpUnsigned,
    output Rv32Pkg::PcSel_t     o_PcNextSel
);
    import Rv32Pkg::*;

    logic isTaken;                              // Branch condition met
    AluOp funcOp;                               // ALU op from funct fields

    assign o_CmpUnsigned = (i_Funct3 == F3_BLTU) || (i_Funct3 == F3_BGEU);

    always_comb begin
        case (i_Funct3)
            F3_BEQ:           isTaken = i_IsEq;
            F3_BNE:           isTaken = !i_IsEq;
            F3_BLT, F3_BLTU:  isTaken = i_IsLt;
            F3_BGE, F3_BGEU:  isTaken = !i_IsLt;
            default:          isTaken = 1'b0;   // Reserved encodings
        endcase
    end

    // ----------------------------------------
    // ALU operation for OP and OP-IMM
    // ----------------------------------------

    always_comb begin
        case (i_Funct3)
            // Bit 30 is immediate data for ADDI
            F3_ADD:  funcOp = (i_Op == OP_REG && i_Funct7b5) ? ALU_SUB : ALU_ADD;
            F3_SLL:  funcOp = ALU_SLL;
            F3_SLT:  funcOp = ALU_SLT;
            F3_SLTU: funcOp = ALU_SLTU;
            F3_XOR:  funcOp = ALU_XOR;
            F3_SR:   funcOp = i_Funct7b5 ? ALU_SRA : ALU_SRL;
            F3_OR:   funcOp = ALU_OR;
            default: funcOp = ALU_AND;
        endcase
    end

    // ----------------------------------------
    // Main decode
    // ----------------------------------------

    always_comb begin
        o_AluControl   = ALU_ADD;               // Defaults give a no-op
        o_RegWrEnable  = 1'b0;
        o_MemWrEnable  = 1'b0;
        o_RegWrDataSel = SEL_ALU;
        o_OperandASel  = 1'b0;
        o_OperandBSel  = 1'b0;
        o_PcNextSel    = PC_PLUS4;
        case (i_Op)
            OP_REG: begin
                o_RegWrEnable = 1'b1;
                o_AluControl  = funcOp;
            end
            OP_IMM: begin
                o_RegWrEnable = 1'b1;
                o_OperandBSel = 1'b1;
                o_AluControl  = funcOp;
            end
            OP_LOAD: begin
                o_RegWrEnable  = 1'b1;
                o_OperandBSel  = 1'b1;          // Address is rs1 + imm
                o_RegWrDataSel = SEL_MEM;
            end
            OP_STORE: begin
                o_MemWrEnable = 1'b1;
                o_OperandBSel = 1'b1;
            end
            OP_BRANCH:
                o_PcNextSel = isTaken ? PC_REL : PC_PLUS4;
            OP_JAL: begin
                o_RegWrEnable  = 1'b1;
                o_OperandBSel  = 1'b1;
                o_RegWrDataSel = SEL_PC4;
                o_PcNextSel    = PC_REL;
            end
            OP_JALR: begin
                o_RegWrEnable  = 1'b1;
                o_OperandBSel  = 1'b1;
                o_RegWrDataSel = SEL_PC4;
                o_PcNextSel    = PC_REG;
            end
            OP_LUI: begin
                o_RegWrEnable = 1'b1;
                o_OperandBSel = 1'b1;
                o_AluControl  = ALU_PASSB;      // Result is the U immediate
            end
            OP_AUIPC: begin
                o_RegWrEnable = 1'b1;
                o_OperandASel = 1'b1;           // PC + U immediate
                o_OperandBSel = 1'b1;
            end
            default: ;                          // FENCE, CSR, ECALL and unknown
        endcase
    end

endmodule

// ==== source/DecodeTop.sv ====
`timescale 1ns/100ps

module DecodeTop (
    input  logic                i_Clock,
    input  logic                i_arstN,
    // Fetch handshake
    input  logic                i_InstReq,
    input  Rv32Pkg::Inst_t      i_Inst,
    input  Rv32Pkg::Pc_t        i_Pc,
    output logic                o_InstAck,
    // Writeback port
    input  logic                i_RegWrEnable,
    input  Rv32Pkg::RegIdx_t    i_RegWrAddr,
    input  Rv32Pkg::Word_t      i_RegWrData,
    // Execute handshake and ID/EX bundle
    output logic                o_ExReq,
    input  logic                i_ExAck,
    output Rv32Pkg::Opcode_t    o_Op,
    output Rv32Pkg::RegIdx_t    o_Rs1,
    output Rv32Pkg::RegIdx_t    o_Rs2,
    output Rv32Pkg::RegIdx_t    o_Rd,
    output Rv32Pkg::Word_t      o_DataA,
    output Rv32Pkg::Word_t      o_DataB,
    output Rv32Pkg::Word_t      o_MemWrData,
    output logic                o_RegWrEnable,
    output logic                o_MemWrEnable,
    output Rv32Pkg::WrDataSel_t o_RegWrDataSel,
    output Rv32Pkg::AluOp       o_AluControl,
    output logic                o_OperandASel,
    output Rv32Pkg::Pc_t        o_PcNext
);
    import Rv32Pkg::*;

    Opcode_t    idOp;
    RegIdx_t    idRs1, idRs2, idRd;
    Word_t      idDataA, idDataB, idMemWrData;
    logic       idRegWrEnable, idMemWrEnable, idOperandASel;
    WrDataSel_t idRegWrDataSel;
    AluOp       idAluControl;
    Pc_t        idPcNext;

    HsState_t hsState;
    logic     capture;                          // Accept a new instruction
    logic     ackNext;
    logic     reqNext;

    StageID stage (
        .i_Clock        (i_Clock),
        .i_arstN        (i_arstN),
        .i_Inst         (i_Inst),
        .i_Pc           (i_Pc),
        .i_RegWrAddr    (i_RegWrAddr),
        .i_RegWrData    (i_RegWrData),
        .i_RegWrEnable  (i_RegWrEnable),
        .o_Op           (idOp),
        .o_Rs1          (idRs1),
        .o_Rs2          (idRs2),
        .o_Rd           (idRd),
        .o_DataA        (idDataA),
        .o_DataB        (idDataB),
        .o_MemWrData    (idMemWrData),
        .o_RegWrEnable  (idRegWrEnable),
        .o_MemWrEnable  (idMemWrEnable),
        .o_RegWrDataSel (idRegWrDataSel),
        .o_AluControl   (idAluControl),
        .o_OperandASel  (idOperandASel),
        .o_PcNext       (idPcNext));

    // ----------------------------------------
    // Four-phase handshake FSM
    // ----------------------------------------

    assign capture = (hsState == IDLE) && i_InstReq;
    assign ackNext = o_InstAck && i_InstReq;    // Drops once req seen low
    assign reqNext = o_ExReq && !i_ExAck;       // Drops once ack seen high

    always_ff @(posedge i_Clock or negedge i_arstN) begin
        if (!i_arstN) begin
            hsState   <= IDLE;
            o_InstAck <= 1'b0;
            o_ExReq   <= 1'b0;
        end else begin
            case (hsState)
                IDLE: if (capture) begin
                    o_InstAck <= 1'b1;          // Both rise on the capture edge
                    o_ExReq   <= 1'b1;
                    hsState   <= HOLD;
                end
                HOLD: begin
                    o_InstAck <= ackNext;       // Either side may finish first
                    o_ExReq   <= reqNext;
                    if (!ackNext && !reqNext)
                        hsState <= DRAIN;
                end
                DRAIN: if (!i_ExAck)
                    hsState <= IDLE;            // Execute finished its return phase
                default: hsState <= IDLE;
            endcase
        end
    end

    // ----------------------------------------
    // ID/EX register
    // ----------------------------------------

    always_ff @(posedge i_Clock or negedge i_arstN) begin
        if (!i_arstN) begin
            o_Op           <= '0;
            o_Rs1          <= '0;
            o_Rs2          <= '0;
            o_Rd           <= '0;
            o_DataA        <= '0;
            o_DataB        <= '0;
            o_MemWrData    <= '0;
            o_RegWrEnable  <= 1'b0;
            o_MemWrEnable  <= 1'b0;
            o_RegWrDataSel <= SEL_ALU;
            o_AluControl   <= ALU_ADD;
            o_OperandASel  <= 1'b0;
            o_PcNext       <= '0;
        end else if (capture) begin             // Held stable until next IDLE
            o_Op           <= idOp;
            o_Rs1          <= idRs1;
            o_Rs2          <= idRs2;
            o_Rd           <= idRd;
            o_DataA        <= idDataA;
            o_DataB        <= idDataB;
            o_MemWrData    <= idMemWrData;
            o_RegWrEnable  <= idRegWrEnable;
            o_MemWrEnable  <= idMemWrEnable;
            o_RegWrDataSel <= idRegWrDataSel;
            o_AluControl   <= idAluControl;
            o_OperandASel  <= idOperandASel;
            o_PcNext       <= idPcNext;
        end
    end

endmodule

// ==== source/InstDecoder.sv ====
`timescale 1ns/100ps

module InstDecoder (
    input  Rv32Pkg::Inst_t   i_Inst,
    output Rv32Pkg::Opcode_t o_Op,
    output Rv32Pkg::RegIdx_t o_Rs1,
    output Rv32Pkg::RegIdx_t o_Rs2,
    output Rv32Pkg::RegIdx_t o_Rd,
    output logic [2:0]       o_Funct3,
    output logic             o_Funct7b5,       // SUB and SRA marker
    output Rv32Pkg::Word_t   o_Imm
);
    import Rv32Pkg::*;

    logic isShift;                              // Shift by immediate

    // Fixed field positions
    assign o_Op       = i_Inst[6:0];
    assign o_Rd       = i_Inst[11:7];
    assign o_Funct3   = i_Inst[14:12];
    assign o_Rs1      = i_Inst[19:15];
    assign o_Rs2      = i_Inst[24:20];
    assign o_Funct7b5 = i_Inst[30];

    assign isShift = (o_Funct3 == F3_SLL) || (o_Funct3 == F3_SR);

    // ----------------------------------------
    // Immediate by format
    // ----------------------------------------

    always_comb begin
        case (o_Op)
            OP_IMM: begin
                if (isShift)
                    o_Imm = {27'b0, i_Inst[24:20]};            // Shift amount only
                else
                    o_Imm = {{20{i_Inst[31]}}, i_Inst[31:20]};
            end
            OP_JALR, OP_LOAD:
                o_Imm = {{20{i_Inst[31]}}, i_Inst[31:20]};     // I format
            OP_STORE:
                o_Imm = {{20{i_Inst[31]}}, i_Inst[31:25], i_Inst[11:7]};
            OP_BRANCH:
                o_Imm = {{19{i_Inst[31]}}, i_Inst[31], i_Inst[7],
                         i_Inst[30:25], i_Inst[11:8], 1'b0};
            OP_LUI, OP_AUIPC:
                o_Imm = {i_Inst[31:12], 12'b0};                // U format
            OP_JAL:
                o_Imm = {{11{i_Inst[31]}}, i_Inst[31], i_Inst[19:12],
                         i_Inst[20], i_Inst[30:21], 1'b0};
            default:
                o_Imm = '0;
        endcase
    end

endmodule

// ==== source/RegisterFile.sv ====
`timescale 1ns/100ps

module RegisterFile (
    input  logic             i_Clock,
    input  logic             i_arstN,
    // Write port
    input  logic             i_WrEnable,
    input  Rv32Pkg::RegIdx_t i_WrAddr,
    input  Rv32Pkg::Word_t   i_WrData,
    // Read ports
    input  Rv32Pkg::RegIdx_t i_RdAddrA,
    output Rv32Pkg::Word_t   o_RdDataA,
    input  Rv32Pkg::RegIdx_t i_RdAddrB,
    output Rv32Pkg::Word_t   o_RdDataB
);
    import Rv32Pkg::*;

    Word_t regs [2**REG_WIDTH];

    // x0 never written so it stays zero after reset
    always_ff @(posedge i_Clock or negedge i_arstN) begin
        if (!i_arstN) begin
            for (int i = 0; i < 2**REG_WIDTH; i++)
                regs[i] <= '0;
        end else if (i_WrEnable && i_WrAddr != '0) begin
            regs[i_WrAddr] <= i_WrData;
        end
    end

    // Reads see a write only after its edge
    assign o_RdDataA = regs[i_RdAddrA];
    assign o_RdDataB = regs[i_RdAddrB];

endmodule

// ==== source/Rv32Pkg.sv ====
package Rv32Pkg;

    // ----------------------------------------
    // Widths and plain vector types
    // ----------------------------------------

    localparam int DATA_WIDTH = 32;             // Register data and immediate
    localparam int REG_WIDTH  = 5;              // Register index
    localparam int PC_WIDTH   = 32;             // Instruction address

    typedef logic [DATA_WIDTH-1:0] Word_t;
    typedef logic [REG_WIDTH-1:0]  RegIdx_t;
    typedef logic [PC_WIDTH-1:0]   Pc_t;
    typedef logic [31:0]           Inst_t;      // Fixed RV32 encoding
    typedef logic [6:0]            Opcode_t;

    // ----------------------------------------
    // Opcodes and funct3 fields
    // ----------------------------------------

    localparam Opcode_t OP_LUI    = 7'b0110111;
    localparam Opcode_t OP_AUIPC  = 7'b0010111;
    localparam Opcode_t OP_JAL    = 7'b1101111;
    localparam Opcode_t OP_JALR   = 7'b1100111;
    localparam Opcode_t OP_BRANCH = 7'b1100011;
    localparam Opcode_t OP_LOAD   = 7'b0000011;  // Word only
    localparam Opcode_t OP_STORE  = 7'b0100011;  // Word only
    localparam Opcode_t OP_IMM    = 7'b0010011;
    localparam Opcode_t OP_REG    = 7'b0110011;

    // ALU funct3
    localparam logic [2:0] F3_ADD  = 3'b000;    // ADD and SUB
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;    // SRL and SRA
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // Branch funct3
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // ----------------------------------------
    // Control encodings
    // ----------------------------------------

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLL,
        ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU, ALU_PASSB
    } AluOp;

    typedef logic [1:0] WrDataSel_t;            // Writeback data source
    localparam WrDataSel_t SEL_ALU = 2'd0;
    localparam WrDataSel_t SEL_MEM = 2'd1;
    localparam WrDataSel_t SEL_PC4 = 2'd2;      // Link address

    typedef logic [1:0] PcSel_t;
    localparam PcSel_t PC_PLUS4 = 2'd0;
    localparam PcSel_t PC_REL   = 2'd1;         // PC + imm
    localparam PcSel_t PC_REG   = 2'd2;         // rs1 + imm, bit 0 cleared

    // Handshake FSM of the top level
    typedef enum logic [1:0] {IDLE, HOLD, DRAIN} HsState_t;

endpackage

// ==== source/StageID.sv ====
`timescale 1ns/100ps

module StageID (
    input  logic                i_Clock,
    input  logic                i_arstN,
    // From fetch
    input  Rv32Pkg::Inst_t      i_Inst,
    input  Rv32Pkg::Pc_t        i_Pc,
    // From writeback
    input  Rv32Pkg::RegIdx_t    i_RegWrAddr,
    input  Rv32Pkg::Word_t      i_RegWrData,
    input  logic                i_RegWrEnable,
    // Decoded bundle
    output Rv32Pkg::Opcode_t    o_Op,
    output Rv32Pkg::RegIdx_t    o_Rs1,
    output Rv32Pkg::RegIdx_t    o_Rs2,
    output Rv32Pkg::RegIdx_t    o_Rd,
    output Rv32Pkg::Word_t      o_DataA,
    output Rv32Pkg::Word_t      o_DataB,
    output Rv32Pkg::Word_t      o_MemWrData,
    output logic                o_RegWrEnable,
    output logic                o_MemWrEnable,
    output Rv32Pkg::WrDataSel_t o_RegWrDataSel,
    output Rv32Pkg::AluOp       o_AluControl,
    output logic                o_OperandASel,
    output Rv32Pkg::Pc_t        o_PcNext
);
    import Rv32Pkg::*;

    logic [2:0] decFunct3;
    logic       decFunct7b5;
    Word_t      decImm;
    logic       ctrlOperandBSel;
    logic       ctrlCmpUnsigned;
    PcSel_t     ctrlPcNextSel;
    Word_t      regDataB;                       // rs2 before the B mux
    logic       cmpIsEq;
    logic       cmpIsLt;

    InstDecoder decoder (
        .i_Inst     (i_Inst),
        .o_Op       (o_Op),
        .o_Rs1      (o_Rs1),
        .o_Rs2      (o_Rs2),
        .o_Rd       (o_Rd),
        .o_Funct3   (decFunct3),
        .o_Funct7b5 (decFunct7b5),
        .o_Imm      (decImm));

    Controller ctrl (
        .i_Op           (o_Op),
        .i_Funct3       (decFunct3),
        .i_Funct7b5     (decFunct7b5),
        .i_IsEq         (cmpIsEq),
        .i_IsLt         (cmpIsLt),
        .o_AluControl   (o_AluControl),
        .o_RegWrEnable  (o_RegWrEnable),
        .o_MemWrEnable  (o_MemWrEnable),
        .o_RegWrDataSel (o_RegWrDataSel),
        .o_OperandASel  (o_OperandASel),
        .o_OperandBSel  (ctrlOperandBSel),
        .o_CmpUnsigned  (ctrlCmpUnsigned),
        .o_PcNextSel    (ctrlPcNextSel));

    // Written only from the writeback port
    RegisterFile regs (
        .i_Clock    (i_Clock),
        .i_arstN    (i_arstN),
        .i_WrEnable (i_RegWrEnable),
        .i_WrAddr   (i_RegWrAddr),
        .i_WrData   (i_RegWrData),
        .i_RdAddrA  (o_Rs1),
        .o_RdDataA  (o_DataA),
        .i_RdAddrB  (o_Rs2),
        .o_RdDataB  (regDataB));

    BranchUnit branch (
        .i_Pc        (i_Pc),
        .i_Imm       (decImm),
        .i_DataA     (o_DataA),
        .i_DataB     (regDataB),
        .i_Unsigned  (ctrlCmpUnsigned),
        .i_PcNextSel (ctrlPcNextSel),
        .o_IsEq      (cmpIsEq),
        .o_IsLt      (cmpIsLt),
        .o_PcNext    (o_PcNext));

    // Operand B mux
    assign o_DataB     = ctrlOperandBSel ? decImm : regDataB;
    assign o_MemWrData = regDataB;              // Store data is always rs2

endmodule

// ==== tb/DecodeTop_props.sv ====
`timescale 1ns/100ps

module DecodeTop_props (
    input logic               i_Clock,
    input logic               i_arstN,
    input logic               i_InstReq,
    input logic               i_InstAck,
    input logic               i_ExReq,
    input logic               i_ExAck,
    input Rv32Pkg::HsState_t  i_State,
    input logic [158:0]       i_Bundle          // Whole ID/EX register concatenated
);
    import Rv32Pkg::*;

    int failCount = 0;                          // Failed assertion count

    // ----------------------------------------
    // Fetch side
    // ----------------------------------------

    // Ack follows a request sampled at the capture edge
    ackAfterReq: assert property (@(posedge i_Clock) disable iff (!i_arstN)
        $rose(i_InstAck) |-> $past(i_InstReq))
        else begin
            $error("o_InstAck rose without a fetch request");
            failCount++;
        end

    // ----------------------------------------
    // Execute side
    // ----------------------------------------

    reqNotDuringAck: assert property (@(posedge i_Clock) disable iff (!i_arstN)
        $rose(i_ExReq) |-> !$past(i_ExAck))
        else begin
            $error("o_ExReq rose while i_ExAck was still high");
            failCount++;
        end

    // Bundle frozen from the request until execute acks
    bundleStable: assert property (@(posedge i_Clock) disable iff (!i_arstN)
        (i_ExReq && !i_ExAck && $past(i_ExReq)) |-> $stable(i_Bundle))
        else begin
            $error("ID/EX bundle changed while o_ExReq was waiting");
            failCount++;
        end

    idleQuiet: assert property (@(posedge i_Clock) disable iff (!i_arstN)
        (i_State == IDLE) |-> (!i_InstAck && !i_ExReq))
        else begin
            $error("handshake outputs high in IDLE");
            failCount++;
        end

    resetQuiet: assert property (@(posedge i_Clock)
        !i_arstN |-> (!i_InstAck && !i_ExReq))
        else begin
            $error("handshake outputs high during reset");
            failCount++;
        end

endmodule

bind DecodeTop DecodeTop_props props (
    .i_Clock   (i_Clock),
    .i_arstN   (i_arstN),
    .i_InstReq (i_InstReq),
    .i_InstAck (o_InstAck),
    .i_ExReq   (o_ExReq),
    .i_ExAck   (i_ExAck),
    .i_State   (hsState),
    .i_Bundle  ({o_Op, o_Rs1, o_Rs2, o_Rd, o_DataA, o_DataB, o_MemWrData,
                 o_RegWrEnable, o_MemWrEnable, o_RegWrDataSel, o_AluControl,
                 o_OperandASel, o_PcNext}));

// ==== tb/DecodeTop_tb.sv ====
`timescale 1ns/100ps

module DecodeTop_tb;
    import Rv32Pkg::*;

    // DUT ports
    logic       i_Clock;
    logic       i_arstN;
    logic       i_InstReq;
    Inst_t      i_Inst;
    Pc_t        i_Pc;
    logic       o_InstAck;
    logic       i_RegWrEnable;
    RegIdx_t    i_RegWrAddr;
    Word_t      i_RegWrData;
    logic       o_ExReq;
    logic       i_ExAck;
    Opcode_t    o_Op;
    RegIdx_t    o_Rs1;
    RegIdx_t    o_Rs2;
    RegIdx_t    o_Rd;
    Word_t      o_DataA;
    Word_t      o_DataB;
    Word_t      o_MemWrData;
    logic       o_RegWrEnable;
    logic       o_MemWrEnable;
    WrDataSel_t o_RegWrDataSel;
    AluOp       o_AluControl;
    logic       o_OperandASel;
    Pc_t        o_PcNext;

    // Cases file contents with 15 fields per I line
    byte         itemKind [$];                  // W or I in file order
    int          itemIndex [$];
    RegIdx_t     wrAddr [$];
    Word_t       wrData [$];
    logic [31:0] caseFld [$];
    int          numCases = 0;

    int unsigned lcgState   = 21;               // LCG seed
    int          cycleCount = 0;
    int          cycleLimit = 0;                // 0 until the file is read
    int          fetchAcks  = 0;
    int          exDone     = 0;
    bit          running    = 1'b0;

    DecodeTop UUT (.*);

    // ----------------------------------------
    // Helpers
    // ----------------------------------------

    function automatic int unsigned lcgNext();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState;
    endfunction

    function automatic logic [31:0] field(input int k, input int pos);
        return caseFld[k * 15 + pos];
    endfunction

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic nextCycle();
        @(posedge i_Clock);
        #1;                                     // Drive and sample point
    endtask

    task automatic checkWord(input string name, input Word_t exp, input Word_t act);
        if (act !== exp)
            abortRun($sformatf("[ERROR] %t: %s expected %h, got %h", $time, name, exp, act));
    endtask

    task automatic checkPc(input string name, input Pc_t exp, input Pc_t act);
        if (act !== exp)
            abortRun($sformatf("[ERROR] %t: %s expected %h, got %h", $time, name, exp, act));
    endtask

    task automatic checkOp(input string name, input Opcode_t exp, input Opcode_t act);
        if (act !== exp)
            abortRun($sformatf("[ERROR] %t: %s expected %h, got %h", $time, name, exp, act));
    endtask

    task automatic checkIdx(input string name, input RegIdx_t exp, input RegIdx_t act);
        if (act !== exp)
            abortRun($sformatf("[ERROR] %t: %s expected x%0d, got x%0d", $time, name, exp, act));
    endtask

    task automatic checkAlu(input string name, input AluOp exp, input AluOp act);
        if (act !== exp)
            abortRun($sformatf("[ERROR] %t: %s expected %s, got %0d",
                               $time, name, exp.name(), act));
    endtask

    task automatic checkSel(input string name, input WrDataSel_t exp, input WrDataSel_t act);
        if (act !== exp)
            abortRun($sformatf("[ERROR] %t: %s expected %0d, got %0d", $time, name, exp, act));
    endtask

    task automatic checkBit(input string name, input logic exp, input logic act);
        if (act !== exp)
            abortRun($sformatf("[ERROR] %t: %s expected %b, got %b", $time, name, exp, act));
    endtask

    // ----------------------------------------
    // Cases file
    // ----------------------------------------

    task automatic readCases();
        int          fd;
        int          n;
        string       line;
        logic [31:0] f [15];
        fd = $fopen("tb/decode_cases.txt", "r");
        if (fd == 0)
            abortRun("could not open tb/decode_cases.txt");
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 0 && line.getc(0) == "W") begin
                n = $sscanf(line, "W %h %h", f[0], f[1]);
                if (n != 2)
                    abortRun({"malformed W line in cases file: ", line});
                itemKind.push_back("W");
                itemIndex.push_back(wrAddr.size());
                wrAddr.push_back(RegIdx_t'(f[0]));
                wrData.push_back(f[1]);
            end else if (n > 0 && line.getc(0) == "I") begin
                n = $sscanf(line, "I %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                            f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
                            f[8], f[9], f[10], f[11], f[12], f[13], f[14]);
                if (n != 15)
                    abortRun({"malformed I line in cases file: ", line});
                itemKind.push_back("I");
                itemIndex.push_back(numCases);
                for (int i = 0; i < 15; i++)
                    caseFld.push_back(f[i]);
                numCases++;
            end                                 // Comments and blank lines skipped
        end
        $fclose(fd);
    endtask

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------

    task automatic writeReg(input RegIdx_t addr, input Word_t data);
        i_RegWrAddr   = addr;
        i_RegWrData   = data;
        i_RegWrEnable = 1'b1;
        nextCycle();                            // Written on this edge
        i_RegWrEnable = 1'b0;
    endtask

    // Four phases toward fetch
    task automatic fetchCase(input int k);
        i_Inst    = Inst_t'(field(k, 0));
        i_Pc      = Pc_t'(field(k, 1));
        i_InstReq = 1'b1;
        do nextCycle(); while (!o_InstAck);
        i_InstReq = 1'b0;
        do nextCycle(); while (o_InstAck);
    endtask

    task automatic checkBundle(input int k);
        checkOp("o_Op", Opcode_t'(field(k, 2)), o_Op);
        checkIdx("o_Rs1", RegIdx_t'(field(k, 3)), o_Rs1);
        checkIdx("o_Rs2", RegIdx_t'(field(k, 4)), o_Rs2);
        checkIdx("o_Rd", RegIdx_t'(field(k, 5)), o_Rd);
        checkWord("o_DataA", field(k, 6), o_DataA);
        checkWord("o_DataB", field(k, 7), o_DataB);
        checkWord("o_MemWrData", field(k, 8), o_MemWrData);
        checkBit("o_RegWrEnable", field(k, 9) != 0, o_RegWrEnable);
        checkBit("o_MemWrEnable", field(k, 10) != 0, o_MemWrEnable);
        checkSel("o_RegWrDataSel", WrDataSel_t'(field(k, 11)), o_RegWrDataSel);
        checkAlu("o_AluControl", AluOp'(field(k, 12)), o_AluControl);
        checkBit("o_OperandASel", field(k, 13) != 0, o_OperandASel);
        checkPc("o_PcNext", Pc_t'(field(k, 14)), o_PcNext);
    endtask

    initial begin : clockGen
        i_Clock = 1'b0;
        forever #2 i_Clock = ~i_Clock;          // 4 ns period
    end

    always @(posedge i_Clock) begin : watchdog
        cycleCount++;
        if (cycleLimit != 0 && cycleCount > cycleLimit)
            abortRun("timeout: handshake stalled");
    end

    initial begin : assertWatch
        wait (UUT.props.failCount != 0);
        abortRun("a handshake assertion on DecodeTop failed");
    end

    // Execute side with random back-pressure
    initial begin : executeSide
        int delay;
        wait (running);
        forever begin
            nextCycle();
            if (o_ExReq && !i_ExAck) begin
                if (exDone >= numCases)
                    abortRun("execute request with no instruction left to expect");
                checkBundle(exDone);
                delay = int'((lcgNext() >> 16) % 6);    // 0 to 5 cycles
                repeat (delay) nextCycle();
                i_ExAck = 1'b1;
                do nextCycle(); while (o_ExReq);
                delay = int'((lcgNext() >> 16) % 6);    // Ack held into the return phase
                repeat (delay) nextCycle();
                i_ExAck = 1'b0;
                exDone++;
            end
        end
    end

    initial begin : ackMonitor
        logic ackPrev;
        ackPrev = 1'b0;
        forever begin
            nextCycle();
            if (o_InstAck && !ackPrev)
                fetchAcks++;                    // Count rising edges only
            ackPrev = o_InstAck;
        end
    end

    initial begin : mainFlow
        $timeformat(-9, 1, " ns", 0);
        i_arstN       = 1'b1;
        i_InstReq     = 1'b0;
        i_Inst        = '0;
        i_Pc          = '0;
        i_RegWrEnable = 1'b0;
        i_RegWrAddr   = '0;
        i_RegWrData   = '0;
        i_ExAck       = 1'b0;
        readCases();
        cycleLimit = 8 + 40 * numCases + 2 * wrAddr.size();
        #1 i_arstN = 1'b0;                      // Clean falling edge
        repeat (8) @(posedge i_Clock);
        #1 i_arstN = 1'b1;
        running = 1'b1;
        for (int i = 0; i < itemKind.size(); i++) begin
            if (itemKind[i] == "W")
                writeReg(wrAddr[itemIndex[i]], wrData[itemIndex[i]]);
            else
                fetchCase(itemIndex[i]);
        end
        while (exDone < numCases)
            nextCycle();
        repeat (4) nextCycle();                 // Catch a late duplicate ack
        if (fetchAcks == numCases) begin
            $display("TB PASSED");
            $finish;
        end else begin
            abortRun($sformatf("[ERROR] %t: %0d fetch acks for %0d cases",
                               $time, fetchAcks, numCases));
        end
    end

endmodule

// ==== tb/decode_cases.txt ====
# W addr data : write register through the writeback port
# I inst pc op rs1 rs2 rd dataA dataB memWrData regWe memWe sel alu opASel pcNext (hex)
W 01 00000005
W 02 FFFFFFF0
W 03 00000005
W 04 00001000
I 402082B3 00000100 33 01 02 05 00000005 FFFFFFF0 FFFFFFF0 1 0 0 1 0 00000104
I 40115333 00000104 33 02 01 06 FFFFFFF0 00000005 00000005 1 0 0 7 0 00000108
I 003133B3 00000108 33 02 03 07 FFFFFFF0 00000005 00000005 1 0 0 9 0 0000010C
I 40315413 0000010C 13 02 03 08 FFFFFFF0 00000003 00000005 1 0 0 7 0 00000110
I FFD08493 00000110 13 01 1D 09 00000005 FFFFFFFD 00000000 1 0 0 0 0 00000114
I 00822503 00000114 03 04 08 0A 00001000 00000008 00000000 1 0 1 0 0 00000118
I FE222E23 00000118 23 04 02 1C 00001000 FFFFFFFC FFFFFFF0 0 1 0 0 0 0000011C
I 00308863 00000200 63 01 03 10 00000005 00000005 00000005 0 0 0 0 0 00000210
I 00208863 00000204 63 01 02 10 00000005 FFFFFFF0 FFFFFFF0 0 0 0 0 0 00000208
I FE209CE3 00000208 63 01 02 19 00000005 FFFFFFF0 FFFFFFF0 0 0 0 0 0 00000200
I 00309863 0000020C 63 01 03 10 00000005 00000005 00000005 0 0 0 0 0 00000210
I 00114863 00000210 63 02 01 10 FFFFFFF0 00000005 00000005 0 0 0 0 0 00000220
I 0020C863 00000214 63 01 02 10 00000005 FFFFFFF0 FFFFFFF0 0 0 0 0 0 00000218
I 0020D863 00000218 63 01 02 10 00000005 FFFFFFF0 FFFFFFF0 0 0 0 0 0 00000228
I 00115863 0000021C 63 02 01 10 FFFFFFF0 00000005 00000005 0 0 0 0 0 00000220
I FE20ECE3 00000220 63 01 02 19 00000005 FFFFFFF0 FFFFFFF0 0 0 0 0 0 00000218
I 00116863 00000224 63 02 01 10 FFFFFFF0 00000005 00000005 0 0 0 0 0 00000228
I 00117863 00000228 63 02 01 10 FFFFFFF0 00000005 00000005 0 0 0 0 0 00000238
I 0020F863 0000022C 63 01 02 10 00000005 FFFFFFF0 FFFFFFF0 0 0 0 0 0 00000230
I 100000EF 00000300 6F 00 00 01 00000000 00000100 00000000 1 0 2 0 0 00000400
I 021202E7 00000304 67 04 01 05 00001000 00000021 00000005 1 0 2 0 0 00001020
I ABCDE5B7 00000308 37 1B 1C 0B 00000000 ABCDE000 00000000 1 0 0 A 0 0000030C
I 12345617 0000030C 17 08 03 0C 00000000 12345000 00000005 1 0 0 0 1 00000310
W 00 DEADBEEF
I 001006B3 00000310 33 00 01 0D 00000000 00000005 00000005 1 0 0 0 0 00000314
W 01 0000007B
I 001006B3 00000314 33 00 01 0D 00000000 0000007B 0000007B 1 0 0 0 0 00000318
